// ==== include/pifo_defines.svh ====
`ifndef PIFO_DEFINES_SVH
`define PIFO_DEFINES_SVH

// ---------------------------------------------------------------------------
// Data widths
// ---------------------------------------------------------------------------

// Stored value, all ones marks an empty slot
`define PIFO_VALUE_W 16

// Entries below a slot, 84 fits easily
`define PIFO_COUNT_W 8

// ---------------------------------------------------------------------------
// Tree shape
// ---------------------------------------------------------------------------

`define PIFO_LEVELS 3  // Root plus two levels
`define PIFO_SLOTS  4  // Slots per node

// Node index within a level, 16 leaf nodes
`define PIFO_NODE_ADDR_W 4

`endif

// ==== src/pifo_data_pkg.sv ====
`include "pifo_defines.svh"

package pifo_data_pkg;

    // Queued value, all ones means the slot is empty
    typedef logic [`PIFO_VALUE_W-1:0] value_t;

    // Number of entries in the subtree below a slot
    typedef logic [`PIFO_COUNT_W-1:0] count_t;

    // Slot position within one node
    typedef logic [$clog2(`PIFO_SLOTS)-1:0] slot_idx_t;

    // One node memory word
    // Slot s sits at bits [s*24 +: 24], count above value, slot 0 lowest
    typedef logic [`PIFO_SLOTS*(`PIFO_COUNT_W+`PIFO_VALUE_W)-1:0] node_word_t;

endpackage

// ==== src/pifo_ctrl_pkg.sv ====
`include "pifo_defines.svh"

package pifo_ctrl_pkg;

    // Stage states of one tree level
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_push = 2'b01,
        st_pop  = 2'b11,
        st_wb   = 2'b10   // Pop refill write
    } level_state_t;

    // Node index within a level
    // Child of node n through slot s is node 4n+s
    typedef logic [`PIFO_NODE_ADDR_W-1:0] node_addr_t;

endpackage

// ==== src/pifo_node_ram.sv ====
`include "pifo_defines.svh"

module pifo_node_ram #(
    parameter int DEPTH = 1  // Nodes in this level
) (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_rd_en,
    input  pifo_ctrl_pkg::node_addr_t i_rd_addr,
    output pifo_data_pkg::node_word_t o_rd_data,
    input  logic                      i_wr_en,
    input  pifo_ctrl_pkg::node_addr_t i_wr_addr,
    input  pifo_data_pkg::node_word_t i_wr_data
);

    // Every slot empty with a zero count
    localparam pifo_data_pkg::node_word_t EMPTY_WORD =
        {`PIFO_SLOTS{{`PIFO_COUNT_W{1'b0}}, {`PIFO_VALUE_W{1'b1}}}};

    pifo_data_pkg::node_word_t mem [DEPTH];
    pifo_data_pkg::node_word_t mem_word;

    // Read mux over the stored nodes
    always_comb begin
        mem_word = mem[0];
        for (int i = 0; i < DEPTH; i++) begin
            if (i_rd_addr == pifo_ctrl_pkg::node_addr_t'(i)) begin
                mem_word = mem[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= EMPTY_WORD;
            end
            o_rd_data <= EMPTY_WORD;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (i_wr_en && i_wr_addr == pifo_ctrl_pkg::node_addr_t'(i)) begin
                    mem[i] <= i_wr_data;
                end
            end
            if (i_rd_en) begin
                // Write-first on an address collision
                o_rd_data <= (i_wr_en && i_wr_addr == i_rd_addr) ? i_wr_data : mem_word;
            end
        end
    end

endmodule

// ==== src/pifo_slot_select.sv ====
`include "pifo_defines.svh"

module pifo_slot_select (
    input  pifo_data_pkg::node_word_t i_word,
    output pifo_data_pkg::slot_idx_t  o_min_count_slot,  // Push target
    output pifo_data_pkg::slot_idx_t  o_min_value_slot   // Pop source
);

    localparam int SLOT_W = `PIFO_VALUE_W + `PIFO_COUNT_W;

    pifo_data_pkg::count_t counts [`PIFO_SLOTS];
    pifo_data_pkg::value_t values [`PIFO_SLOTS];

    // ---------------------------------------------------------------------------
    // Split the node word into its slot fields
    // ---------------------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < `PIFO_SLOTS; s++) begin
            values[s] = i_word[s*SLOT_W +: `PIFO_VALUE_W];
            counts[s] = i_word[s*SLOT_W + `PIFO_VALUE_W +: `PIFO_COUNT_W];
        end
    end

    // ---------------------------------------------------------------------------
    // Minimum scans, strict compare keeps the lowest index on a tie
    // ---------------------------------------------------------------------------

    // Least populated subtree
    always_comb begin : count_scan
        pifo_data_pkg::count_t best_count;
        best_count       = counts[0];
        o_min_count_slot = '0;
        for (int s = 1; s < `PIFO_SLOTS; s++) begin
            if (counts[s] < best_count) begin
                best_count       = counts[s];
                o_min_count_slot = pifo_data_pkg::slot_idx_t'(s);
            end
        end
    end

    // Smallest stored value, empty slots lose by their all-ones value
    always_comb begin : value_scan
        pifo_data_pkg::value_t best_value;
        best_value       = values[0];
        o_min_value_slot = '0;
        for (int s = 1; s < `PIFO_SLOTS; s++) begin
            if (values[s] < best_value) begin
                best_value       = values[s];
                o_min_value_slot = pifo_data_pkg::slot_idx_t'(s);
            end
        end
    end

endmodule

// ==== src/pifo_level.sv ====
`include "pifo_defines.svh"

module pifo_level #(
    parameter int LEVEL = 0  // 0 is the root
) (
    input  logic                      i_clk,
    input  logic                      i_arst_n,

    // Parent side
    input  logic                      i_push,
    input  pifo_data_pkg::value_t     i_push_value,
    input  logic                      i_pop,
    input  pifo_ctrl_pkg::node_addr_t i_node_addr,
    output pifo_data_pkg::value_t     o_pop_value,

    // Child side
    output logic                      o_push,
    output pifo_data_pkg::value_t     o_push_value,
    output logic                      o_pop,
    output pifo_ctrl_pkg::node_addr_t o_child_addr,
    input  pifo_data_pkg::value_t     i_child_pop_value,

    // Status
    output logic                      o_ready,
    output logic                      o_pop_valid
);

    localparam int VALUE_W = `PIFO_VALUE_W;
    localparam int COUNT_W = `PIFO_COUNT_W;
    localparam int SLOT_W  = VALUE_W + COUNT_W;
    localparam int IDX_W   = $bits(pifo_data_pkg::slot_idx_t);
    localparam int DEPTH   = `PIFO_SLOTS ** LEVEL;    // 1, 4, 16 nodes
    localparam bit FORWARD = (LEVEL < `PIFO_LEVELS - 1);  // Leaf keeps everything

    localparam pifo_data_pkg::value_t EMPTY_VALUE = '1;

    // ---------------------------------------------------------------------------
    // Declarations
    // ---------------------------------------------------------------------------
    pifo_ctrl_pkg::level_state_t r_state;
    pifo_ctrl_pkg::node_addr_t   r_addr;       // Node under update
    pifo_data_pkg::value_t       r_push_value;

    logic cmd_push;
    logic cmd_pop;
    logic accept;

    pifo_data_pkg::node_word_t rd_word;
    pifo_data_pkg::node_word_t wr_word;
    logic                      wr_en;

    pifo_data_pkg::slot_idx_t cnt_slot;
    pifo_data_pkg::slot_idx_t val_slot;
    pifo_data_pkg::slot_idx_t sel_slot;
    pifo_data_pkg::value_t    sel_value;
    pifo_data_pkg::count_t    sel_count;

    pifo_data_pkg::value_t new_value;
    pifo_data_pkg::count_t new_count;
    logic                  push_fwd;
    pifo_data_pkg::value_t push_fwd_value;

    // One command at a time, push with pop together is dropped
    assign cmd_push = i_push & ~i_pop;
    assign cmd_pop  = i_pop & ~i_push;
    assign accept   = (r_state != pifo_ctrl_pkg::st_pop) & (cmd_push | cmd_pop);

    // ---------------------------------------------------------------------------
    // Command FSM
    // ---------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= pifo_ctrl_pkg::st_idle;
            r_addr  <= '0;
        end else begin
            case (r_state)
                pifo_ctrl_pkg::st_pop: begin
                    r_state <= pifo_ctrl_pkg::st_wb;  // Child value arrives next
                end
                default: begin
                    if (cmd_push) begin
                        r_state <= pifo_ctrl_pkg::st_push;
                        r_addr  <= i_node_addr;
                    end else if (cmd_pop) begin
                        r_state <= pifo_ctrl_pkg::st_pop;
                        r_addr  <= i_node_addr;
                    end else begin
                        r_state <= pifo_ctrl_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && cmd_push) begin
            r_push_value <= i_push_value;
        end
    end

    // ---------------------------------------------------------------------------
    // Node memory and slot choice
    // ---------------------------------------------------------------------------
    pifo_node_ram #(
        .DEPTH (DEPTH)
    ) u_ram (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rd_en   (accept),
        .i_rd_addr (i_node_addr),
        .o_rd_data (rd_word),
        .i_wr_en   (wr_en),
        .i_wr_addr (r_addr),
        .i_wr_data (wr_word)
    );

    pifo_slot_select u_select (
        .i_word           (rd_word),
        .o_min_count_slot (cnt_slot),
        .o_min_value_slot (val_slot)
    );

    // Push goes to the lightest subtree, pop takes the minimum value
    assign sel_slot  = (r_state == pifo_ctrl_pkg::st_push) ? cnt_slot : val_slot;
    assign sel_value = rd_word[sel_slot*SLOT_W +: VALUE_W];
    assign sel_count = rd_word[sel_slot*SLOT_W + VALUE_W +: COUNT_W];

    // ---------------------------------------------------------------------------
    // Word update
    // ---------------------------------------------------------------------------
    always_comb begin
        wr_en          = 1'b0;
        wr_word        = rd_word;
        new_value      = sel_value;
        new_count      = sel_count;
        push_fwd       = 1'b0;
        push_fwd_value = r_push_value;
        case (r_state)
            pifo_ctrl_pkg::st_push: begin
                wr_en     = 1'b1;
                new_count = pifo_data_pkg::count_t'(sel_count + 1'b1);
                if (sel_value == EMPTY_VALUE) begin
                    new_value = r_push_value;  // Free slot, nothing moves down
                end else begin
                    push_fwd = 1'b1;
                    if (r_push_value < sel_value) begin
                        new_value      = r_push_value;
                        push_fwd_value = sel_value;  // Displaced entry sinks
                    end
                end
                wr_word[sel_slot*SLOT_W +: SLOT_W] = {new_count, new_value};
            end
            pifo_ctrl_pkg::st_wb: begin
                wr_en = 1'b1;
                // Refill from the child only if the slot held something
                if (sel_count != '0) begin
                    new_count = pifo_data_pkg::count_t'(sel_count - 1'b1);
                    new_value = i_child_pop_value;
                end
                wr_word[sel_slot*SLOT_W +: SLOT_W] = {new_count, new_value};
            end
            default: begin
            end
        endcase
    end

    // ---------------------------------------------------------------------------
    // Outputs
    // ---------------------------------------------------------------------------
    assign o_pop_value  = (r_state == pifo_ctrl_pkg::st_pop) ? sel_value : EMPTY_VALUE;

    assign o_push       = FORWARD ? push_fwd : 1'b0;
    assign o_push_value = push_fwd_value;
    assign o_pop        = FORWARD ? (r_state == pifo_ctrl_pkg::st_pop ||
                                     r_state == pifo_ctrl_pkg::st_wb) : 1'b0;
    assign o_child_addr = {r_addr[`PIFO_NODE_ADDR_W-IDX_W-1:0], sel_slot};  // 4n + s

    assign o_ready      = (r_state != pifo_ctrl_pkg::st_pop);
    assign o_pop_valid  = (r_state == pifo_ctrl_pkg::st_pop);

endmodule

// ==== src/pifo_top.sv ====
`include "pifo_defines.svh"

module pifo_top (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_push,
    input  pifo_data_pkg::value_t i_push_value,
    input  logic                  i_pop,
    output logic                  o_ready,
    output logic                  o_pop_valid,
    output pifo_data_pkg::value_t o_pop_data
);

    // Link k feeds stage k, stage k drives link k+1
    logic                      push_c     [`PIFO_LEVELS+1];
    pifo_data_pkg::value_t     push_val_c [`PIFO_LEVELS+1];
    logic                      pop_c      [`PIFO_LEVELS+1];
    pifo_ctrl_pkg::node_addr_t addr_c     [`PIFO_LEVELS+1];
    pifo_data_pkg::value_t     pop_val_c  [`PIFO_LEVELS+1];  // Returned upwards
    logic                      ready_c    [`PIFO_LEVELS];
    logic                      valid_c    [`PIFO_LEVELS];

    // External side of the root
    assign push_c[0]     = i_push;
    assign push_val_c[0] = i_push_value;
    assign pop_c[0]      = i_pop;
    assign addr_c[0]     = '0;  // Single root node

    // Nothing below the leaves
    assign pop_val_c[`PIFO_LEVELS] = '1;

    // ---------------------------------------------------------------------------
    // Stage pipeline
    // ---------------------------------------------------------------------------
    for (genvar k = 0; k < `PIFO_LEVELS; k++) begin : g_level
        pifo_level #(
            .LEVEL (k)
        ) u_level (
            .i_clk             (i_clk),
            .i_arst_n          (i_arst_n),
            .i_push            (push_c[k]),
            .i_push_value      (push_val_c[k]),
            .i_pop             (pop_c[k]),
            .i_node_addr       (addr_c[k]),
            .o_pop_value       (pop_val_c[k]),
            .o_push            (push_c[k+1]),
            .o_push_value      (push_val_c[k+1]),
            .o_pop             (pop_c[k+1]),
            .o_child_addr      (addr_c[k+1]),
            .i_child_pop_value (pop_val_c[k+1]),
            .o_ready           (ready_c[k]),
            .o_pop_valid       (valid_c[k])
        );
    end

    // Only the root faces the outside
    assign o_ready     = ready_c[0];
    assign o_pop_valid = valid_c[0];
    assign o_pop_data  = pop_val_c[0];

endmodule

// ==== sim/pifo_asserts.sv ====
module pifo_asserts (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_push,
    input logic i_pop,
    input logic i_ready,
    input logic i_pop_valid
);

    logic pop_accept;

    // Root takes a lone pop whenever it reports ready
    assign pop_accept = i_pop && !i_push && i_ready;

    // ------------------------------------------------------------------------
    // Command protocol at the top level
    // ------------------------------------------------------------------------
    a_single_cmd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_push && i_pop))
        else $error("push and pop presented in the same cycle");

    a_valid_after_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        pop_accept |=> i_pop_valid)
        else $error("o_pop_valid missing one cycle after an accepted pop");

    // No stray valid strobes
    a_valid_from_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pop_valid |-> $past(pop_accept))
        else $error("o_pop_valid high without a pop accepted one cycle before");

    a_busy_after_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        pop_accept |=> !i_ready)
        else $error("o_ready high in the cycle after an accepted pop");

endmodule

bind pifo_top pifo_asserts u_asserts (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_push      (i_push),
    .i_pop       (i_pop),
    .i_ready     (o_ready),
    .i_pop_valid (o_pop_valid)
);

// ==== sim/pifo_tb.sv ====
`include "pifo_defines.svh"

module pifo_tb;

    localparam int TIMEOUT_CYCLES = 50;

    logic                  i_clk;
    logic                  i_arst_n;
    logic                  i_push;
    pifo_data_pkg::value_t i_push_value;
    logic                  i_pop;
    logic                  o_ready;
    logic                  o_pop_valid;
    pifo_data_pkg::value_t o_pop_data;

    pifo_data_pkg::value_t model_q[$];   // Reference queue contents
    pifo_data_pkg::value_t expect_q[$];  // Pop results still to arrive
    logic [15:0]           lfsr_state;
    int                    checks;
    int                    errors;
    int                    ready_errors;  // Handshake errors seen after pops

    pifo_top u_dut (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_push       (i_push),
        .i_push_value (i_push_value),
        .i_pop        (i_pop),
        .o_ready      (o_ready),
        .o_pop_valid  (o_pop_valid),
        .o_pop_data   (o_pop_data)
    );

    always #4 i_clk = ~i_clk;

    // ------------------------------------------------------------------------
    // Stimulus source
    // ------------------------------------------------------------------------

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[14:0], lfsr_state[0]};
        end
    endtask

    task automatic rand_value(output pifo_data_pkg::value_t v);
        logic [15:0] bits;
        take_bits(`PIFO_VALUE_W, bits);
        v = pifo_data_pkg::value_t'(bits);
        if (v == '1) begin
            v = '0;  // All ones is the empty marker
        end
    endtask

    // Removes and returns the smallest queued value
    function automatic pifo_data_pkg::value_t ref_pop_min();
        int                    min_idx;
        pifo_data_pkg::value_t min_val;
        min_idx = -1;
        min_val = '1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (min_idx < 0 || model_q[i] < min_val) begin
                min_idx = i;
                min_val = model_q[i];
            end
        end
        if (min_idx >= 0) begin
            model_q.delete(min_idx);
        end
        return min_val;
    endfunction

    // ------------------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input pifo_data_pkg::value_t got,
                               input pifo_data_pkg::value_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%04h, expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name, input int n_err);
        if (n_err == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, n_err);
        end
    endtask

    // Pop results sampled on the falling edge
    always @(negedge i_clk) begin : compare_pop
        pifo_data_pkg::value_t exp_value;
        if (i_arst_n && o_pop_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("A pop result appeared while no pop was outstanding");
            end else begin
                exp_value = expect_q.pop_front();
                check_value("o_pop_data", o_pop_data, exp_value);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Command tasks entered and left 1 unit after a rising edge
    // ------------------------------------------------------------------------
    task automatic wait_ready();
        int n;
        n = 0;
        while (!o_ready && n < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            #1;
            n++;
        end
        if (!o_ready) begin
            $display("Timeout: o_ready stayed low for %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic push_value(input pifo_data_pkg::value_t v);
        wait_ready();
        i_push       = 1'b1;
        i_push_value = v;
        model_q.push_back(v);
        @(posedge i_clk);
        #1;
        i_push = 1'b0;
    endtask

    task automatic pop_value();
        int err0;
        wait_ready();
        expect_q.push_back(ref_pop_min());
        i_pop = 1'b1;
        @(posedge i_clk);
        #1;
        i_pop = 1'b0;
        check_bit("o_pop_valid", o_pop_valid, 1'b1);
        err0  = errors;
        check_bit("o_ready", o_ready, 1'b0);  // Busy while the result is out
        ready_errors += errors - err0;
        @(posedge i_clk);
        #1;
        err0 = errors;
        check_bit("o_ready", o_ready, 1'b1);
        ready_errors += errors - err0;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin : main_seq
        int                    err0;
        logic [15:0]           bits;
        pifo_data_pkg::value_t v;
        i_clk        = 1'b0;
        i_arst_n     = 1'b0;
        i_push       = 1'b0;
        i_push_value = '0;
        i_pop        = 1'b0;
        lfsr_state   = 16'd43;
        checks       = 0;
        errors       = 0;
        ready_errors = 0;
        repeat (3) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;
        @(posedge i_clk);
        #1;

        err0 = errors;
        check_bit("o_ready", o_ready, 1'b1);
        check_bit("o_pop_valid", o_pop_valid, 1'b0);
        report_test(1, "idle after reset", errors - err0);

        err0 = errors;
        pop_value();
        report_test(2, "pop on empty queue", errors - err0);

        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            rand_value(v);
            push_value(v);
        end
        for (int i = 0; i < 20; i++) begin
            pop_value();
        end
        report_test(3, "twenty pushes then twenty pops", errors - err0);

        // Occupancy kept at 16 or less so no leaf node overflows
        err0 = errors;
        for (int i = 0; i < 80; i++) begin
            take_bits(1, bits);
            if ((bits[0] && model_q.size() > 0) || model_q.size() >= 16) begin
                pop_value();
            end else begin
                rand_value(v);
                push_value(v);
            end
        end
        while (model_q.size() > 0) begin
            pop_value();
        end
        report_test(4, "random push and pop mix", errors - err0);

        err0 = errors;
        for (int i = 0; i < 84; i++) begin
            rand_value(v);
            push_value(v);
        end
        for (int i = 0; i < 84; i++) begin
            pop_value();
        end
        pop_value();  // Empty marker expected once drained
        report_test(5, "fill to capacity and drain", errors - err0);

        report_test(6, "ready low for one cycle after each pop", ready_errors);

        if (expect_q.size() != 0) begin
            errors++;
            $display("%0d pop results never arrived", expect_q.size());
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
src/pifo_data_pkg.sv
src/pifo_ctrl_pkg.sv
src/pifo_node_ram.sv
src/pifo_slot_select.sv
src/pifo_level.sv
src/pifo_top.sv
sim/pifo_asserts.sv
sim/pifo_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = pifo_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Fails when the log holds the fail message or lacks the pass message
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
